// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := exec_stage_tb
FILELIST := exec_unit.f
OBJ_DIR  := obj_dir
PASS_MSG := >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with $(TOOL) and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run fails unless the pass line shows up in the output
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== design/exec_alu.sv ====
`include "exec_params.svh"

module exec_alu (
    input  rv_pkg::word_t   op_a,
    input  rv_pkg::word_t   op_b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::word_t   result
);

    import rv_pkg::*;

    // shift amount is the low five bits of op_b
    logic [4:0] shamt;

    // signed views for slt and sra
    logic signed [`EXEC_XLEN-1:0] op_a_s;
    logic signed [`EXEC_XLEN-1:0] op_b_s;

    assign shamt  = op_b[4:0];
    assign op_a_s = $signed(op_a);
    assign op_b_s = $signed(op_b);

    always_comb begin
        unique case (op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            // set less than, result is 0 or 1
            ALU_SLT:  result = word_t'(op_a_s < op_b_s);
            ALU_SLTU: result = word_t'(op_a < op_b);
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result = word_t'(op_a_s >>> shamt);
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            // unused encodings
            default:  result = '0;
        endcase
    end

endmodule

// ==== design/exec_branch_cmp.sv ====
module exec_branch_cmp (
    input  rv_pkg::word_t   rs1,
    input  rv_pkg::word_t   rs2,
    input  rv_pkg::cmp_op_e op,
    output logic            taken
);

    import rv_pkg::*;

    // shared compare results
    logic equal;
    logic less_s;
    logic less_u;

    assign equal  = (rs1 == rs2);
    assign less_s = ($signed(rs1) < $signed(rs2));
    assign less_u = (rs1 < rs2);

    always_comb begin
        unique case (op)
            CMP_EQ:  taken = equal;
            CMP_NE:  taken = !equal;
            CMP_LT:  taken = less_s;
            CMP_GE:  taken = !less_s;
            CMP_LTU: taken = less_u;
            CMP_GEU: taken = !less_u;
            // never a branch
            default: taken = 1'b0;
        endcase
    end

endmodule

// ==== design/exec_mul_counter.sv ====
`include "exec_params.svh"

module exec_mul_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic step,
    output logic last
);

    import exec_pkg::*;

    mul_cnt_t cnt;

    // counts down from steps-1 to zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= mul_cnt_t'(`EXEC_MUL_STEPS - 1);
        end else if (step) begin
            cnt <= cnt - 1'b1;
        end
    end

    // final iteration in progress
    assign last = (cnt == '0);

    // the step at zero is the last one, nothing may follow it without a reload
    a_no_extra_step: assert property (@(posedge clk) disable iff (!rst_n)
        (step && last) |=> !step);

endmodule

// ==== design/exec_mul_ctrl.sv ====
module exec_mul_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic stall,
    input  logic flush,
    input  logic last,
    output logic load,
    output logic step,
    output logic mul_done,
    output logic stage_ready
);

    import exec_pkg::*;

    mul_state_e state;
    mul_state_e state_next;

    // kick off when a mul sits in the flop
    assign load     = (state == MUL_IDLE) && start && !stall && !flush;
    // one iteration per unstalled cycle
    assign step     = (state == MUL_RUN) && !stall && !flush;
    assign mul_done = (state == MUL_DONE);

    // low from mul capture until the product is out
    // flush always frees the flop for the next instruction
    assign stage_ready = flush || mul_done || ((state == MUL_IDLE) && !start);

    always_comb begin
        state_next = state;
        if (flush) begin
            state_next = MUL_IDLE;
        end else if (!stall) begin
            unique case (state)
                MUL_IDLE: if (start) state_next = MUL_RUN;
                MUL_RUN:  if (last) state_next = MUL_DONE;
                MUL_DONE: state_next = MUL_IDLE;
                default:  state_next = MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= MUL_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // the flop stays closed while the multiplier iterates
    a_step_busy: assert property (@(posedge clk) disable iff (!rst_n)
        step |-> !stage_ready);

    // a frozen stage keeps its state, so it never restarts the multiplier
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(state));

endmodule

// ==== design/exec_mul_datapath.sv ====
module exec_mul_datapath (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          load,
    input  logic          step,
    input  rv_pkg::word_t multiplicand,
    input  rv_pkg::word_t multiplier,
    output rv_pkg::word_t product
);

    import rv_pkg::*;

    // multiplicand moves left, multiplier right
    word_t mcand_q;
    word_t mplier_q;
    word_t acc_q;

    always_ff @(posedge clk) begin
        if (load) begin
            mcand_q  <= multiplicand;
            mplier_q <= multiplier;
        end else if (step) begin
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    // accumulator keeps only the low word
    // bits shifted past xlen never reach it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (load) begin
            acc_q <= '0;
        end else if (step && mplier_q[0]) begin
            acc_q <= acc_q + mcand_q;
        end
    end

    // low word of the unsigned product, same as rv32 mul
    assign product = acc_q;

endmodule

// ==== design/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// data path width
`define EXEC_XLEN 32

// destination register index width
`define EXEC_REG_IDX_W 5

// csr immediate (zimm) width
`define EXEC_ZIMM_W 5

// one shift-add iteration per multiplier bit
`define EXEC_MUL_STEPS `EXEC_XLEN

// wide enough to hold EXEC_MUL_STEPS - 1
`define EXEC_MUL_CNT_W 6

`endif

// ==== design/exec_pkg.sv ====
`include "exec_params.svh"

package exec_pkg;

    // first alu operand
    typedef enum logic [1:0] {
        OP1_SRC_RS1,
        OP1_SRC_PC,
        OP1_SRC_CSR,
        OP1_SRC_ZERO
    } op1_src_e;

    // second alu operand
    typedef enum logic [1:0] {
        OP2_SRC_RS1,
        OP2_SRC_RS2,
        OP2_SRC_IMM,
        OP2_SRC_FOUR
    } op2_src_e;

    // csr modify operand, register or zimm
    typedef enum logic {
        CSR_SRC_RS1,
        CSR_SRC_ZIMM
    } csr_src_e;

    // csrrw / csrrs / csrrc style updates
    typedef enum logic [1:0] {
        CSR_OP_PASS,
        CSR_OP_SET,
        CSR_OP_CLEAR
    } csr_op_e;

    // multiplier sequencing
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_e;

    // remaining shift-add iterations
    typedef logic [`EXEC_MUL_CNT_W-1:0] mul_cnt_t;

endpackage

// ==== design/exec_stage.sv ====
`include "exec_params.svh"

module exec_stage (
    input  logic               clk,
    input  logic               rst_n,
    // from decode
    input  logic               in_valid,
    input  rv_pkg::word_t      pc,
    input  rv_pkg::word_t      rs1_val,
    input  rv_pkg::word_t      rs2_val,
    input  rv_pkg::word_t      imm,
    input  rv_pkg::word_t      csr_old_val,
    input  rv_pkg::zimm_t      zimm,
    input  rv_pkg::alu_op_e    alu_op,
    input  exec_pkg::op1_src_e op1_src,
    input  exec_pkg::op2_src_e op2_src,
    input  rv_pkg::cmp_op_e    cmp_op,
    input  exec_pkg::csr_src_e csr_src,
    input  exec_pkg::csr_op_e  csr_op,
    input  logic               is_mul,
    input  rv_pkg::reg_idx_t   rd_idx,
    input  logic               rd_we,
    // hazard unit
    input  logic               stall,
    input  logic               flush,
    output logic               stage_ready,
    // to memory
    output logic               out_valid,
    output rv_pkg::word_t      result,
    output logic               branch_taken,
    output rv_pkg::word_t      csr_new_val,
    output rv_pkg::reg_idx_t   rd_idx_out,
    output logic               rd_we_out
);

    import rv_pkg::*;
    import exec_pkg::*;

    // input flop
    logic     ff_valid;
    word_t    ff_pc;
    word_t    ff_rs1;
    word_t    ff_rs2;
    word_t    ff_imm;
    word_t    ff_csr_old;
    zimm_t    ff_zimm;
    alu_op_e  ff_alu_op;
    op1_src_e ff_op1_src;
    op2_src_e ff_op2_src;
    cmp_op_e  ff_cmp_op;
    csr_src_e ff_csr_src;
    csr_op_e  ff_csr_op;
    logic     ff_is_mul;
    reg_idx_t ff_rd_idx;
    logic     ff_rd_we;

    // decode holds its fields while we are busy
    logic capture;
    assign capture = !stall && stage_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_valid <= 1'b0;
        end else if (capture) begin
            ff_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            ff_pc      <= pc;
            ff_rs1     <= rs1_val;
            ff_rs2     <= rs2_val;
            ff_imm     <= imm;
            ff_csr_old <= csr_old_val;
            ff_zimm    <= zimm;
            ff_alu_op  <= alu_op;
            ff_op1_src <= op1_src;
            ff_op2_src <= op2_src;
            ff_cmp_op  <= cmp_op;
            ff_csr_src <= csr_src;
            ff_csr_op  <= csr_op;
            ff_is_mul  <= is_mul;
            ff_rd_idx  <= rd_idx;
            ff_rd_we   <= rd_we;
        end
    end

    // alu operand muxes
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;

    always_comb begin
        unique case (ff_op1_src)
            OP1_SRC_RS1:  alu_a = ff_rs1;
            OP1_SRC_PC:   alu_a = ff_pc;
            OP1_SRC_CSR:  alu_a = ff_csr_old;
            OP1_SRC_ZERO: alu_a = '0;
        endcase
    end

    always_comb begin
        unique case (ff_op2_src)
            OP2_SRC_RS1:  alu_b = ff_rs1;
            OP2_SRC_RS2:  alu_b = ff_rs2;
            OP2_SRC_IMM:  alu_b = ff_imm;
            // return address for jal/jalr
            OP2_SRC_FOUR: alu_b = word_t'(4);
        endcase
    end

    exec_alu u_alu (
        .op_a   (alu_a),
        .op_b   (alu_b),
        .op     (ff_alu_op),
        .result (alu_result)
    );

    exec_branch_cmp u_branch_cmp (
        .rs1   (ff_rs1),
        .rs2   (ff_rs2),
        .op    (ff_cmp_op),
        .taken (branch_taken)
    );

    // csr operand, zimm zero extended
    word_t csr_operand;
    assign csr_operand = (ff_csr_src == CSR_SRC_ZIMM) ?
        {{(`EXEC_XLEN - `EXEC_ZIMM_W){1'b0}}, ff_zimm} : ff_rs1;

    always_comb begin
        unique case (ff_csr_op)
            CSR_OP_PASS:  csr_new_val = csr_operand;
            CSR_OP_SET:   csr_new_val = ff_csr_old | csr_operand;
            CSR_OP_CLEAR: csr_new_val = ff_csr_old & ~csr_operand;
            default:      csr_new_val = csr_operand;
        endcase
    end

    // multiplier
    logic  mul_start;
    logic  mul_load;
    logic  mul_step;
    logic  mul_last;
    logic  mul_done;
    word_t mul_product;

    assign mul_start = ff_valid && ff_is_mul;

    exec_mul_ctrl u_mul_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (mul_start),
        .stall       (stall),
        .flush       (flush),
        .last        (mul_last),
        .load        (mul_load),
        .step        (mul_step),
        .mul_done    (mul_done),
        .stage_ready (stage_ready)
    );

    exec_mul_counter u_mul_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (mul_load),
        .step  (mul_step),
        .last  (mul_last)
    );

    exec_mul_datapath u_mul_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (mul_load),
        .step         (mul_step),
        .multiplicand (ff_rs1),
        .multiplier   (ff_rs2),
        .product      (mul_product)
    );

    // outputs, an unfinished mul stays invisible
    assign out_valid  = ff_valid && !flush && !stall && (!ff_is_mul || mul_done);
    assign result     = mul_done ? mul_product : alu_result;
    assign rd_idx_out = ff_rd_idx;
    assign rd_we_out  = ff_rd_we;

    // hazard unit contract
    a_no_stall_flush: assert property (@(posedge clk) disable iff (!rst_n)
        !(stall && flush));

endmodule

// ==== design/rv_pkg.sv ====
`include "exec_params.svh"

package rv_pkg;

    // isa level quantities
    typedef logic [`EXEC_XLEN-1:0]      word_t;
    typedef logic [`EXEC_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`EXEC_ZIMM_W-1:0]    zimm_t;

    // rv32i integer alu operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // branch conditions
    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU
    } cmp_op_e;

endpackage

// ==== exec_unit.f ====
+incdir+design
design/rv_pkg.sv
design/exec_pkg.sv
design/exec_alu.sv
design/exec_branch_cmp.sv
design/exec_mul_ctrl.sv
design/exec_mul_counter.sv
design/exec_mul_datapath.sv
design/exec_stage.sv
test/exec_stage_tb.sv

// ==== test/exec_stage_tb.sv ====
`include "exec_params.svh"

module exec_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_pkg::*;
    import exec_pkg::*;

    localparam int NUM_INSTR   = 400;
    localparam int WAIT_LIMIT  = 200;
    // one idle cycle to load, then one cycle per step
    localparam int MUL_LATENCY = `EXEC_MUL_STEPS + 1;
    localparam int MSB         = `EXEC_XLEN - 1;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    word_t    pc;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
    word_t    csr_old_val;
    zimm_t    zimm;
    alu_op_e  alu_op;
    op1_src_e op1_src;
    op2_src_e op2_src;
    cmp_op_e  cmp_op;
    csr_src_e csr_src;
    csr_op_e  csr_op;
    logic     is_mul;
    reg_idx_t rd_idx;
    logic     rd_we;
    logic     stall;
    logic     flush;
    logic     stage_ready;
    logic     out_valid;
    word_t    result;
    logic     branch_taken;
    word_t    csr_new_val;
    reg_idx_t rd_idx_out;
    logic     rd_we_out;

    // random stall and flush only while this is set
    logic hazards_on;

    // model copy of the instruction in the stage
    logic     m_valid;
    word_t    m_pc;
    word_t    m_rs1;
    word_t    m_rs2;
    word_t    m_imm;
    word_t    m_csr_old;
    zimm_t    m_zimm;
    alu_op_e  m_alu_op;
    op1_src_e m_op1_src;
    op2_src_e m_op2_src;
    cmp_op_e  m_cmp_op;
    csr_src_e m_csr_src;
    csr_op_e  m_csr_op;
    logic     m_is_mul;
    reg_idx_t m_rd_idx;
    logic     m_rd_we;
    // unstalled edges since a mul was captured
    int       m_mul_wait;

    word_t exp_alu;
    word_t exp_result;
    word_t exp_csr;
    logic  exp_taken;
    logic  exp_out_valid;

    // reach counters
    logic [9:0] alu_seen = '0;
    logic [3:0] op1_seen = '0;
    logic [3:0] op2_seen = '0;
    logic [5:0] cmp_seen = '0;
    logic [5:0] csr_seen = '0;
    int         mul_results = 0;
    int         mul_stalls = 0;
    int         mul_flushes = 0;

    exec_stage dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .pc           (pc),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .imm          (imm),
        .csr_old_val  (csr_old_val),
        .zimm         (zimm),
        .alu_op       (alu_op),
        .op1_src      (op1_src),
        .op2_src      (op2_src),
        .cmp_op       (cmp_op),
        .csr_src      (csr_src),
        .csr_op       (csr_op),
        .is_mul       (is_mul),
        .rd_idx       (rd_idx),
        .rd_we        (rd_we),
        .stall        (stall),
        .flush        (flush),
        .stage_ready  (stage_ready),
        .out_valid    (out_valid),
        .result       (result),
        .branch_taken (branch_taken),
        .csr_new_val  (csr_new_val),
        .rd_idx_out   (rd_idx_out),
        .rd_we_out    (rd_we_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input word_t expected, input word_t actual);
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        abort_run();
    endtask

    function automatic word_t first_operand(op1_src_e src, word_t rs1, word_t pc_v, word_t csr);
        case (src)
            OP1_SRC_RS1: return rs1;
            OP1_SRC_PC:  return pc_v;
            OP1_SRC_CSR: return csr;
            default:     return '0;
        endcase
    endfunction

    function automatic word_t second_operand(op2_src_e src, word_t rs1, word_t rs2, word_t im);
        case (src)
            OP2_SRC_RS1: return rs1;
            OP2_SRC_RS2: return rs2;
            OP2_SRC_IMM: return im;
            default:     return word_t'(4);
        endcase
    endfunction

    function automatic word_t alu_result_of(alu_op_e op, word_t a, word_t b);
        logic [4:0] sh;
        word_t      fill;
        logic       lt_s;
        sh   = b[4:0];
        // sign bits vacated by a right shift
        fill = a[MSB] ? ~({`EXEC_XLEN{1'b1}} >> sh) : '0;
        // differing signs settle a signed compare alone
        lt_s = (a[MSB] != b[MSB]) ? a[MSB] : (a < b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return word_t'(lt_s);
            ALU_SLTU: return word_t'(a < b);
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | fill;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_decision(cmp_op_e op, word_t a, word_t b);
        logic lt_s;
        lt_s = (a[MSB] != b[MSB]) ? a[MSB] : (a < b);
        case (op)
            CMP_EQ:  return a == b;
            CMP_NE:  return a != b;
            CMP_LT:  return lt_s;
            CMP_GE:  return !lt_s;
            CMP_LTU: return a < b;
            CMP_GEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t csr_write_value(csr_op_e op, word_t old, word_t operand);
        case (op)
            CSR_OP_SET:   return old | operand;
            CSR_OP_CLEAR: return old & ~operand;
            default:      return operand;
        endcase
    endfunction

    // model follows the capture rule of the stage
    always @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (!stall && stage_ready) begin
            m_valid    <= in_valid;
            m_pc       <= pc;
            m_rs1      <= rs1_val;
            m_rs2      <= rs2_val;
            m_imm      <= imm;
            m_csr_old  <= csr_old_val;
            m_zimm     <= zimm;
            m_alu_op   <= alu_op;
            m_op1_src  <= op1_src;
            m_op2_src  <= op2_src;
            m_cmp_op   <= cmp_op;
            m_csr_src  <= csr_src;
            m_csr_op   <= csr_op;
            m_is_mul   <= is_mul;
            m_rd_idx   <= rd_idx;
            m_rd_we    <= rd_we;
            m_mul_wait <= 0;
        end else if (!stall) begin
            m_mul_wait <= m_mul_wait + 1;
        end
    end

    always_comb begin
        exp_alu = alu_result_of(m_alu_op,
            first_operand(m_op1_src, m_rs1, m_pc, m_csr_old),
            second_operand(m_op2_src, m_rs1, m_rs2, m_imm));
        // rv32 mul keeps the low word
        exp_result = m_is_mul ? word_t'(m_rs1 * m_rs2) : exp_alu;
        exp_taken  = branch_decision(m_cmp_op, m_rs1, m_rs2);
        exp_csr    = csr_write_value(m_csr_op, m_csr_old,
            (m_csr_src == CSR_SRC_ZIMM) ? word_t'(m_zimm) : m_rs1);
        exp_out_valid = m_valid && !stall && !flush && (!m_is_mul || m_mul_wait == MUL_LATENCY);
    end

    // what the stimulus actually reached
    always @(posedge clk) begin
        if (rst_n && out_valid && m_is_mul) begin
            mul_results <= mul_results + 1;
        end else if (rst_n && out_valid) begin
            alu_seen[m_alu_op]  <= 1'b1;
            op1_seen[m_op1_src] <= 1'b1;
            op2_seen[m_op2_src] <= 1'b1;
            cmp_seen[m_cmp_op]  <= 1'b1;
            csr_seen[{m_csr_op, m_csr_src}] <= 1'b1;
        end
        // stalled between load and product
        if (rst_n && stall && m_valid && m_is_mul &&
            m_mul_wait > 0 && m_mul_wait < MUL_LATENCY) begin
            mul_stalls <= mul_stalls + 1;
        end
        // flushed before the product came out
        if (rst_n && flush && m_valid && m_is_mul && m_mul_wait < MUL_LATENCY) begin
            mul_flushes <= mul_flushes + 1;
        end
    end

    a_reset_out_valid: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else value_error("out_valid", 1'b0, $sampled(out_valid));
    a_reset_ready: assert property (@(posedge clk) $rose(rst_n) |-> stage_ready)
        else value_error("stage_ready", 1'b1, $sampled(stage_ready));

    a_out_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !stall && !flush |-> out_valid == exp_out_valid)
        else value_error("out_valid", $sampled(exp_out_valid), $sampled(out_valid));
    a_stall_quiet: assert property (@(posedge clk) disable iff (!rst_n) stall |-> !out_valid)
        else value_error("out_valid", 1'b0, $sampled(out_valid));
    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n) flush |-> !out_valid)
        else value_error("out_valid", 1'b0, $sampled(out_valid));

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> result == exp_result)
        else value_error("result", $sampled(exp_result), $sampled(result));
    a_branch: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> branch_taken == exp_taken)
        else value_error("branch_taken", $sampled(exp_taken), $sampled(branch_taken));
    a_csr: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> csr_new_val == exp_csr)
        else value_error("csr_new_val", $sampled(exp_csr), $sampled(csr_new_val));
    a_rd_idx: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> rd_idx_out == m_rd_idx)
        else value_error("rd_idx_out", $sampled(m_rd_idx), $sampled(rd_idx_out));
    a_rd_we: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> rd_we_out == m_rd_we)
        else value_error("rd_we_out", $sampled(m_rd_we), $sampled(rd_we_out));

    // busy from mul capture until the product is out, stalled or not
    a_mul_busy: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && m_is_mul && !flush |-> stage_ready == (m_mul_wait == MUL_LATENCY))
        else value_error("stage_ready", $sampled(m_mul_wait == MUL_LATENCY), $sampled(stage_ready));
    a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(m_valid && m_is_mul) |-> stage_ready)
        else value_error("stage_ready", 1'b1, $sampled(stage_ready));
    a_flush_ready: assert property (@(posedge clk) disable iff (!rst_n) flush |-> stage_ready)
        else value_error("stage_ready", 1'b1, $sampled(stage_ready));
    // a new mul may be loaded by the flush edge itself
    a_flush_release: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> stage_ready || (m_valid && m_is_mul))
        else value_error("stage_ready", 1'b1, $sampled(stage_ready));

    // one clock edge, reports whether the stage took decode's fields
    task automatic advance_clock(output logic accepted);
        int r;
        @(posedge clk);
        accepted = !stall && stage_ready;
        r = $urandom % 32;
        // never both at once
        stall <= hazards_on && (r < 4);
        flush <= hazards_on && (r == 4);
    endtask

    task automatic send_instruction(input logic must_be_valid);
        word_t a;
        word_t b;
        logic  accepted;
        int    waited;
        a = $urandom;
        // equal operands now and then for eq/ne
        b = ($urandom % 4 == 0) ? a : word_t'($urandom);
        in_valid    <= must_be_valid || ($urandom % 8 != 0);
        pc          <= $urandom;
        rs1_val     <= a;
        rs2_val     <= b;
        imm         <= ($urandom % 2 == 0) ? word_t'($urandom % 64) : word_t'($urandom);
        csr_old_val <= $urandom;
        zimm        <= zimm_t'($urandom);
        alu_op      <= alu_op_e'($urandom % 10);
        op1_src     <= op1_src_e'($urandom % 4);
        op2_src     <= op2_src_e'($urandom % 4);
        cmp_op      <= cmp_op_e'($urandom % 6);
        csr_src     <= csr_src_e'($urandom % 2);
        csr_op      <= csr_op_e'($urandom % 3);
        is_mul      <= ($urandom % 6 == 0);
        rd_idx      <= reg_idx_t'($urandom);
        rd_we       <= ($urandom % 2 == 1);
        accepted = 1'b0;
        waited   = 0;
        // fields stay put until the stage takes them
        while (!accepted && waited < WAIT_LIMIT) begin
            advance_clock(accepted);
            waited++;
        end
        if (!accepted) begin
            $display("decode waited %0d cycles and the stage never took the instruction", waited);
            abort_run();
        end
    endtask

    initial begin
        logic accepted;
        logic seen;
        int   waited;
        void'($urandom(16));
        rst_n       = 1'b0;
        hazards_on  = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        in_valid    = 1'b0;
        pc          = '0;
        rs1_val     = '0;
        rs2_val     = '0;
        imm         = '0;
        csr_old_val = '0;
        zimm        = '0;
        alu_op      = ALU_ADD;
        op1_src     = OP1_SRC_RS1;
        op2_src     = OP2_SRC_RS2;
        cmp_op      = CMP_EQ;
        csr_src     = CSR_SRC_RS1;
        csr_op      = CSR_OP_PASS;
        is_mul      = 1'b0;
        rd_idx      = '0;
        rd_we       = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        hazards_on = 1'b1;
        for (int i = 0; i < NUM_INSTR; i++) begin
            send_instruction(1'b0);
        end
        // quiet pipe for the last one so it must come out
        hazards_on = 1'b0;
        send_instruction(1'b1);
        in_valid <= 1'b0;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < WAIT_LIMIT) begin
            advance_clock(accepted);
            seen = out_valid;
            waited++;
        end
        if (!seen) begin
            $display("out_valid never rose for the last instruction within %0d cycles", waited);
            abort_run();
        end else if (alu_seen != '1 || op1_seen != '1 || op2_seen != '1 || cmp_seen != '1 ||
                     csr_seen != '1 || mul_results == 0 || mul_stalls == 0 ||
                     mul_flushes == 0) begin
            $display("stimulus missed an operation, operand source, stall or flush case");
            abort_run();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule
